//--- compile.f
+incdir+source
+incdir+sim
source/sata_cmd_pkg.sv
source/h2d_command_issue.sv
source/pio_control.sv
source/dma_write_control.sv
source/device_status_report.sv
source/sata_command_layer.sv
sim/sata_command_layer_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal -f compile.f --top-module sata_command_layer_tb \
  -o sata_command_layer_sim || { echo "build failed"; exit 1; }
result="$(./obj_dir/sata_command_layer_sim)"
echo "$result"
echo "$result" | grep -q "TESTBENCH PASSED" && echo "simulation passed" || {
  echo "simulation failed"; exit 1; }

//--- sim/sata_cmd_cases.svh
// Command layer test table
localparam int NUM_CASES = 12;

typedef enum int {K_CMD, K_D2H, K_SDB, K_PIO_RD, K_PIO_WR, K_DMA, K_ESC} kind_e;

// One row of stimulus and expected register contents
typedef struct {
  string                    name;
  kind_e                    kind;
  logic [`SATA_CMD_W-1:0]   cmd;
  logic [`SATA_FEAT_W-1:0]  feat;
  logic [`SATA_COUNT_W-1:0] count;
  logic [`SATA_LBA_W-1:0]   lba;
  ata_status_u              stat;
  ata_status_u              err;
  // Cycles with transport held off during DMA
  int                       hold;
  ata_status_u              exp_status;
  ata_status_u              exp_error;
} case_t;

string case_name [NUM_CASES] = '{
  "cmd_issue_a", "d2h_load_a", "sdb_load_a", "pio_read_a", "pio_write_a", "dma_write_a",
  "d2h_load_b", "cmd_issue_b", "pio_read_b", "dma_write_b", "sdb_load_b", "sync_escape"
};
kind_e case_kind [NUM_CASES] = '{
  K_CMD, K_D2H, K_SDB, K_PIO_RD, K_PIO_WR, K_DMA,
  K_D2H, K_CMD, K_PIO_RD, K_DMA, K_SDB, K_ESC
};

case_t cases [NUM_CASES];

// Random fields, then expected registers from the load rules
task automatic build_cases();
  logic [31:0] r;
  logic [31:0] r_hi;
  ata_status_u held_status;
  ata_status_u held_error;
  held_status.raw = 8'h00;
  held_error.raw  = 8'h00;
  for (int i = 0; i < NUM_CASES; i++) begin
    cases[i].name = case_name[i];
    cases[i].kind = case_kind[i];
    r = $random(seed);
    cases[i].cmd      = r[7:0];
    cases[i].feat     = r[23:8];
    cases[i].stat.raw = r[31:24];
    r = $random(seed);
    cases[i].count   = r[15:0];
    cases[i].err.raw = r[23:16];
    cases[i].hold    = 1 + int'(r[26:24]);
    r_hi = $random(seed);
    r = $random(seed);
    cases[i].lba = {r_hi[15:0], r};
    case (case_kind[i])
      // D2H register FIS loads both bytes
      K_CMD, K_D2H: begin
        held_status = cases[i].stat;
        held_error  = cases[i].err;
      end
      // Status only
      K_SDB, K_PIO_RD, K_PIO_WR: begin
        held_status = cases[i].stat;
      end
      default: begin
      end
    endcase
    cases[i].exp_status = held_status;
    cases[i].exp_error  = held_error;
  end
endtask

//--- sim/sata_command_layer_tb.sv
// SATA command layer testbench
`timescale 1ns/1ns
`include "sata_cmd_cfg.svh"

module sata_command_layer_tb;

  import sata_cmd_pkg::*;

  logic clk;
  logic command_layer_reset;
  logic execute_command_stb, send_sync_escape, data_buffer_ready;
  logic transport_layer_ready, t_dma_activate_stb, t_d2h_reg_stb, t_pio_setup_stb;
  logic t_d2h_data_stb, t_set_device_bits_stb, t_pio_direction, t_if_activate;
  logic [`SATA_CMD_W-1:0]   hard_drive_command, h2d_command;
  logic [`SATA_FEAT_W-1:0]  user_features, h2d_features;
  logic [`SATA_COUNT_W-1:0] sector_count, h2d_sector_count;
  logic [`SATA_LBA_W-1:0]   sector_address, h2d_lba;
  ata_status_u t_pio_e_status, d2h_status, d2h_error, status, error;
  logic command_layer_ready, sata_busy, pio_data_ready, hard_drive_error;
  logic t_send_command_stb, t_send_data_stb, t_if_ready, sync_escape;

  int    seed = 32'h38b46521;
  int    value_errors = 0;
  int    other_errors = 0;
  int    cycle_count = 0;
  string test_name = "reset";

  `include "sata_cmd_cases.svh"

  // Generous per-row budget plus reset
  localparam int TIMEOUT_CYCLES = 40 * NUM_CASES + 4;

  sata_command_layer u_sata_command_layer (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout in %s, run did not finish within %0d cycles", test_name, TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic check_status(input string what, input ata_status_u exp, input ata_status_u act);
    if (act.raw !== exp.raw) begin
      value_errors++;
      $display("error %s %s expected %02h actual %02h", test_name, what, exp.raw, act.raw);
    end
  endtask

  task automatic check_lba(input string what, input logic [`SATA_LBA_W-1:0] exp,
                           input logic [`SATA_LBA_W-1:0] act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("error %s %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  // Rising edge, strobes back to low unless redriven after
  task automatic step();
    @(posedge clk);
    execute_command_stb   <= 1'b0;
    send_sync_escape      <= 1'b0;
    t_dma_activate_stb    <= 1'b0;
    t_d2h_reg_stb         <= 1'b0;
    t_pio_setup_stb       <= 1'b0;
    t_d2h_data_stb        <= 1'b0;
    t_set_device_bits_stb <= 1'b0;
    t_if_activate         <= 1'b0;
  endtask

  task automatic run_case(input case_t c);
    test_name = c.name;
    // Start only once the layer accepts work
    @(negedge clk);
    while (!command_layer_ready) @(negedge clk);
    case (c.kind)
      K_CMD, K_ESC: begin
        step();
        execute_command_stb <= 1'b1;
        hard_drive_command  <= c.cmd;
        user_features       <= c.feat;
        sector_count        <= c.count;
        sector_address      <= c.lba;
        step();
        @(negedge clk);
        check_lba("h2d_command", 48'(c.cmd), 48'(h2d_command));
        check_lba("h2d_features", 48'(c.feat), 48'(h2d_features));
        check_lba("h2d_sector_count", 48'(c.count), 48'(h2d_sector_count));
        check_lba("h2d_lba", c.lba, h2d_lba);
        check_bit("t_send_command_stb", 1'b1, t_send_command_stb);
        check_bit("sata_busy", 1'b1, sata_busy);
        step();
        @(negedge clk);
        check_bit("t_send_command_stb", 1'b0, t_send_command_stb);
        if (c.kind == K_CMD) begin
          step();
          t_d2h_reg_stb <= 1'b1;
          d2h_status    <= c.stat;
          d2h_error     <= c.err;
          step();
          @(negedge clk);
          check_bit("sata_busy", 1'b0, sata_busy);
          check_lba("h2d_features", 48'(`SATA_DEFAULT_FEATURES), 48'(h2d_features));
        end else begin
          // Park DMA in WAIT_FOR_DATA, then escape
          step();
          t_dma_activate_stb <= 1'b1;
          repeat (3) step();
          @(negedge clk);
          check_bit("t_if_ready", 1'b1, t_if_ready);
          check_bit("command_layer_ready", 1'b0, command_layer_ready);
          step();
          send_sync_escape <= 1'b1;
          step();
          @(negedge clk);
          check_bit("command_layer_ready", 1'b1, command_layer_ready);
          check_bit("sata_busy", 1'b0, sata_busy);
          check_bit("sync_escape", 1'b1, sync_escape);
          repeat (2) step();
          @(negedge clk);
          check_bit("sync_escape", 1'b1, sync_escape);
        end
      end
      K_D2H, K_SDB: begin
        step();
        t_d2h_reg_stb         <= (c.kind == K_D2H);
        t_set_device_bits_stb <= (c.kind == K_SDB);
        d2h_status            <= c.stat;
        d2h_error             <= c.err;
        step();
        @(negedge clk);
        // Flag view, MSB first from bsy down to err
        check_bit("hard_drive_error", c.exp_status.raw[0], hard_drive_error);
        check_bit("bsy", c.exp_status.raw[7], status.status_bits.bsy);
        check_bit("drq", c.exp_status.raw[3], status.status_bits.drq);
        check_bit("abrt", c.exp_error.raw[2], error.error_bits.abrt);
      end
      K_PIO_RD, K_PIO_WR: begin
        step();
        t_pio_setup_stb <= 1'b1;
        t_pio_direction <= (c.kind == K_PIO_RD);
        t_pio_e_status  <= c.stat;
        step();
        @(negedge clk);
        check_bit("command_layer_ready", 1'b0, command_layer_ready);
        step();
        t_d2h_data_stb <= (c.kind == K_PIO_RD);
        t_if_activate  <= (c.kind == K_PIO_WR);
        step();
        @(negedge clk);
        check_bit("pio_data_ready", c.kind == K_PIO_RD, pio_data_ready);
        step();
        @(negedge clk);
        check_bit("pio_data_ready", 1'b0, pio_data_ready);
        check_bit("command_layer_ready", 1'b1, command_layer_ready);
      end
      K_DMA: begin
        step();
        t_dma_activate_stb <= 1'b1;
        // Data offered on the third edge after the activate
        for (int k = 1; k <= 3; k++) begin
          step();
          @(negedge clk);
          check_bit("t_if_ready", k == 3, t_if_ready);
        end
        step();
        t_if_activate         <= 1'b1;
        transport_layer_ready <= 1'b0;
        for (int k = 0; k < c.hold; k++) begin
          step();
          @(negedge clk);
          check_bit("t_send_data_stb", 1'b0, t_send_data_stb);
        end
        step();
        transport_layer_ready <= 1'b1;
        step();
        @(negedge clk);
        check_bit("t_send_data_stb", 1'b1, t_send_data_stb);
        step();
        @(negedge clk);
        check_bit("t_send_data_stb", 1'b0, t_send_data_stb);
      end
      default: begin
        other_errors++;
        $display("test %s has a scenario kind that the testbench does not know", c.name);
      end
    endcase
    check_status("status", c.exp_status, status);
    check_status("error", c.exp_error, error);
  endtask

  initial begin
    command_layer_reset   <= 1'b1;
    execute_command_stb   <= 1'b0;
    send_sync_escape      <= 1'b0;
    hard_drive_command    <= '0;
    user_features         <= '0;
    sector_count          <= '0;
    sector_address        <= '0;
    data_buffer_ready     <= 1'b1;
    transport_layer_ready <= 1'b1;
    t_dma_activate_stb    <= 1'b0;
    t_d2h_reg_stb         <= 1'b0;
    t_pio_setup_stb       <= 1'b0;
    t_d2h_data_stb        <= 1'b0;
    t_set_device_bits_stb <= 1'b0;
    t_pio_direction       <= 1'b0;
    t_if_activate         <= 1'b0;
    t_pio_e_status        <= '0;
    d2h_status            <= '0;
    d2h_error             <= '0;
    build_cases();
    repeat (4) @(posedge clk);
    command_layer_reset <= 1'b0;
    @(negedge clk);
    check_bit("sata_busy", 1'b0, sata_busy);
    check_bit("sync_escape", 1'b0, sync_escape);
    check_bit("t_if_ready", 1'b0, t_if_ready);
    check_bit("hard_drive_error", 1'b0, hard_drive_error);
    check_bit("t_send_command_stb", 1'b0, t_send_command_stb);
    check_bit("t_send_data_stb", 1'b0, t_send_data_stb);
    check_bit("pio_data_ready", 1'b0, pio_data_ready);
    check_status("status", '0, status);
    check_status("error", '0, error);
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(cases[i]);
    end
    $display("value errors %0d, other errors %0d", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- source/device_status_report.sv
// Device status and error report
`timescale 1ns/1ns

module device_status_report (
  input  logic                     clk,
  input  logic                     command_layer_reset,
  input  logic                     t_d2h_reg_stb,
  input  logic                     t_set_device_bits_stb,
  input  logic                     pio_status_load,
  input  logic                     pio_idle,
  input  sata_cmd_pkg::ata_status_u d2h_status,
  input  sata_cmd_pkg::ata_status_u d2h_error,
  input  sata_cmd_pkg::ata_status_u t_pio_e_status,
  output sata_cmd_pkg::ata_status_u status,
  output sata_cmd_pkg::ata_status_u error,
  output logic                     hard_drive_error
);

  // Status register
  always_ff @(posedge clk) begin
    if (command_layer_reset) begin
      status.raw <= 8'h00;
    end else if (pio_status_load) begin
      // Ending status carried in the PIO setup FIS
      status.raw <= t_pio_e_status.raw;
    end else if (pio_idle && (t_d2h_reg_stb || t_set_device_bits_stb)) begin
      // Device status only counts outside a PIO flow
      status.raw <= d2h_status.raw;
    end
  end

  // Error register, set-device-bits leaves it alone
  always_ff @(posedge clk) begin
    if (command_layer_reset) begin
      error.raw <= 8'h00;
    end else if (pio_idle && t_d2h_reg_stb) begin
      error.raw <= d2h_error.raw;
    end
  end

  // ERR bit of the held status
  assign hard_drive_error = status.status_bits.err;

endmodule

//--- source/dma_write_control.sv
// DMA write control
`timescale 1ns/1ns

module dma_write_control (
  input  logic clk,
  input  logic command_layer_reset,
  input  logic t_dma_activate_stb,
  input  logic t_if_activate,
  input  logic t_d2h_reg_stb,
  input  logic send_sync_escape,
  input  logic transport_layer_ready,
  input  logic data_buffer_ready,
  input  logic pio_idle,
  output logic command_layer_ready,
  output logic t_if_ready,
  output logic t_send_data_stb,
  output logic sync_escape
);

  import sata_cmd_pkg::*;

  dma_state_e state;
  // Held so a DMA activate is never missed
  logic       dma_act_seen;

  // Both FSMs idle and the transport free
  assign command_layer_ready = pio_idle && (state == DMA_IDLE) && transport_layer_ready;

  // Offer buffered data only while waiting for it
  assign t_if_ready = (state == DMA_WAIT_FOR_DATA) && data_buffer_ready;

  always_ff @(posedge clk) begin
    if (command_layer_reset) begin
      state           <= DMA_IDLE;
      dma_act_seen    <= 1'b0;
      t_send_data_stb <= 1'b0;
      sync_escape     <= 1'b0;
    end else begin
      t_send_data_stb <= 1'b0;

      case (state)
        DMA_IDLE: begin
          if (command_layer_ready && dma_act_seen) begin
            state <= DMA_WAIT_FOR_ACT;
          end
        end
        DMA_WAIT_FOR_ACT: begin
          // Consume the activate
          if (dma_act_seen) begin
            dma_act_seen <= 1'b0;
            state        <= DMA_WAIT_FOR_DATA;
          end
        end
        DMA_WAIT_FOR_DATA: begin
          if (t_if_activate) begin
            state <= DMA_SEND_DATA;
          end
        end
        DMA_SEND_DATA: begin
          // Only stall in the design, may wait indefinitely
          if (transport_layer_ready) begin
            t_send_data_stb <= 1'b1;
            state           <= DMA_IDLE;
          end
        end
        default: begin
          state <= DMA_IDLE;
        end
      endcase

      // A fresh activate always gets recorded
      if (t_dma_activate_stb) begin
        dma_act_seen <= 1'b1;
      end

      // Register FIS ends the transfer
      if (t_d2h_reg_stb) begin
        state <= DMA_IDLE;
      end

      // Escape aborts and stays flagged until reset
      if (send_sync_escape) begin
        state        <= DMA_IDLE;
        dma_act_seen <= 1'b0;
        sync_escape  <= 1'b1;
      end
    end
  end

  // Data FIS strobe only leaves SEND_DATA with transport ready
  a_send_after_send_state : assert property (
    @(posedge clk) disable iff (command_layer_reset)
    t_send_data_stb |-> $past(state == DMA_SEND_DATA && transport_layer_ready)
  );

endmodule

//--- source/h2d_command_issue.sv
// Host to device command issue
`timescale 1ns/1ns
`include "sata_cmd_cfg.svh"

module h2d_command_issue (
  input  logic                     clk,
  input  logic                     command_layer_reset,
  input  logic                     execute_command_stb,
  input  logic                     t_d2h_reg_stb,
  input  logic                     send_sync_escape,
  input  logic [`SATA_CMD_W-1:0]   hard_drive_command,
  input  logic [`SATA_FEAT_W-1:0]  user_features,
  input  logic [`SATA_COUNT_W-1:0] sector_count,
  input  logic [`SATA_LBA_W-1:0]   sector_address,
  output logic [`SATA_CMD_W-1:0]   h2d_command,
  output logic [`SATA_FEAT_W-1:0]  h2d_features,
  output logic [`SATA_COUNT_W-1:0] h2d_sector_count,
  output logic [`SATA_LBA_W-1:0]   h2d_lba,
  output logic                     t_send_command_stb,
  output logic                     sata_busy
);

  // Register FIS payload, captured on each new command
  always_ff @(posedge clk) begin
    if (execute_command_stb) begin
      h2d_command      <= hard_drive_command;
      h2d_sector_count <= sector_count;
      h2d_lba          <= sector_address;
    end
  end

  // Busy flag, features and send strobe
  always_ff @(posedge clk) begin
    if (command_layer_reset) begin
      h2d_features       <= `SATA_DEFAULT_FEATURES;
      sata_busy          <= 1'b0;
      t_send_command_stb <= 1'b0;
    end else begin
      // Strobe follows the user request by one cycle
      t_send_command_stb <= execute_command_stb;
      if (execute_command_stb) begin
        // New command beats a same-cycle device register FIS
        h2d_features <= user_features;
        sata_busy    <= 1'b1;
      end else if (t_d2h_reg_stb || send_sync_escape) begin
        // Device answered or link was escaped
        h2d_features <= `SATA_DEFAULT_FEATURES;
        sata_busy    <= 1'b0;
      end
    end
  end

  // Transport sees each command exactly once
  a_cmd_stb_single : assert property (
    @(posedge clk) disable iff (command_layer_reset)
    t_send_command_stb |=> !t_send_command_stb
  );

endmodule

//--- source/pio_control.sv
// PIO transfer control
`timescale 1ns/1ns

module pio_control (
  input  logic clk,
  input  logic command_layer_reset,
  input  logic t_pio_setup_stb,
  input  logic t_pio_direction,
  input  logic t_d2h_data_stb,
  input  logic t_if_activate,
  input  logic send_sync_escape,
  output logic pio_data_ready,
  output logic pio_status_load,
  output logic pio_idle
);

  import sata_cmd_pkg::*;

  pio_state_e state;

  // Other blocks only start work while PIO is quiet
  assign pio_idle = (state == PIO_IDLE);

  always_ff @(posedge clk) begin
    if (command_layer_reset) begin
      state           <= PIO_IDLE;
      pio_data_ready  <= 1'b0;
      pio_status_load <= 1'b0;
    end else begin
      // Single-cycle strobes
      pio_data_ready  <= 1'b0;
      pio_status_load <= 1'b0;

      if (send_sync_escape) begin
        // Escape aborts any PIO flow
        state <= PIO_IDLE;
      end else begin
        case (state)
          PIO_IDLE: begin
            if (t_pio_setup_stb) begin
              // Direction high means device to host
              if (t_pio_direction) begin
                state <= PIO_WAIT_FOR_DATA;
              end else begin
                state <= PIO_WRITE_DATA;
              end
            end
          end

          PIO_WAIT_FOR_DATA: begin
            // Data FIS arrived, hand it to the user
            if (t_d2h_data_stb) begin
              pio_data_ready  <= 1'b1;
              pio_status_load <= 1'b1;
              state           <= PIO_IDLE;
            end
          end

          PIO_WRITE_DATA: begin
            // Transport pulled the write data
            if (t_if_activate) begin
              pio_status_load <= 1'b1;
              state           <= PIO_IDLE;
            end
          end

          default: begin
            state <= PIO_IDLE;
          end
        endcase
      end
    end
  end

  // Data ready only closes a read
  a_data_ready_after_read : assert property (
    @(posedge clk) disable iff (command_layer_reset)
    pio_data_ready |-> $past(state) == PIO_WAIT_FOR_DATA
  );

endmodule

//--- source/sata_cmd_cfg.svh
// SATA command layer field widths
`ifndef SATA_CMD_CFG_SVH
`define SATA_CMD_CFG_SVH

// ATA command opcode
`define SATA_CMD_W 8

// Features, 16 bits for the 48-bit command set
`define SATA_FEAT_W 16

// Sector count, extended form
`define SATA_COUNT_W 16

// Logical block address, 48-bit addressing
`define SATA_LBA_W 48

// Features value after reset and after each D2H register FIS
`define SATA_DEFAULT_FEATURES 16'h0000

`endif

//--- source/sata_cmd_pkg.sv
// SATA command layer types
package sata_cmd_pkg;

  // ATA status register bits, MSB first
  typedef struct packed {
    logic bsy;
    logic drdy;
    logic dwf;
    logic dsc;
    logic drq;
    logic corr;
    logic idx;
    logic err;
  } ata_status_bits_t;

  // ATA error register bits, MSB first
  typedef struct packed {
    logic bbk;
    logic unc;
    logic mc;
    logic idnf;
    logic mcr;
    logic abrt;
    logic tk0nf;
    logic amnf;
  } ata_error_bits_t;

  // Register byte, seen raw or as named flags
  typedef union packed {
    logic [7:0]       raw;
    ata_status_bits_t status_bits;
    ata_error_bits_t  error_bits;
  } ata_status_u;

  // PIO transfer FSM
  typedef enum logic [1:0] {
    PIO_IDLE,
    PIO_WAIT_FOR_DATA,
    PIO_WRITE_DATA
  } pio_state_e;

  // DMA write FSM
  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_WAIT_FOR_ACT,
    DMA_WAIT_FOR_DATA,
    DMA_SEND_DATA
  } dma_state_e;

endpackage

//--- source/sata_command_layer.sv
// SATA command layer top
`timescale 1ns/1ns
`include "sata_cmd_cfg.svh"

module sata_command_layer (
  input  logic                      clk,
  input  logic                      command_layer_reset,
  // User side
  input  logic                      execute_command_stb,
  input  logic                      send_sync_escape,
  input  logic [`SATA_CMD_W-1:0]    hard_drive_command,
  input  logic [`SATA_FEAT_W-1:0]   user_features,
  input  logic [`SATA_COUNT_W-1:0]  sector_count,
  input  logic [`SATA_LBA_W-1:0]    sector_address,
  input  logic                      data_buffer_ready,
  output logic                      command_layer_ready,
  output logic                      sata_busy,
  output logic                      pio_data_ready,
  output logic                      hard_drive_error,
  output sata_cmd_pkg::ata_status_u status,
  output sata_cmd_pkg::ata_status_u error,
  // Transport side
  input  logic                      transport_layer_ready,
  input  logic                      t_dma_activate_stb,
  input  logic                      t_d2h_reg_stb,
  input  logic                      t_pio_setup_stb,
  input  logic                      t_d2h_data_stb,
  input  logic                      t_set_device_bits_stb,
  input  logic                      t_pio_direction,
  input  logic                      t_if_activate,
  input  sata_cmd_pkg::ata_status_u t_pio_e_status,
  input  sata_cmd_pkg::ata_status_u d2h_status,
  input  sata_cmd_pkg::ata_status_u d2h_error,
  output logic                      t_send_command_stb,
  output logic                      t_send_data_stb,
  output logic                      t_if_ready,
  output logic                      sync_escape,
  // H2D register FIS fields
  output logic [`SATA_CMD_W-1:0]    h2d_command,
  output logic [`SATA_FEAT_W-1:0]   h2d_features,
  output logic [`SATA_COUNT_W-1:0]  h2d_sector_count,
  output logic [`SATA_LBA_W-1:0]    h2d_lba
);

  import sata_cmd_pkg::*;

  logic pio_idle;
  logic pio_status_load;

  h2d_command_issue u_h2d_command_issue (
    .clk, .command_layer_reset,
    .execute_command_stb, .t_d2h_reg_stb, .send_sync_escape,
    .hard_drive_command, .user_features, .sector_count, .sector_address,
    .h2d_command, .h2d_features, .h2d_sector_count, .h2d_lba,
    .t_send_command_stb, .sata_busy
  );

  pio_control u_pio_control (
    .clk, .command_layer_reset,
    .t_pio_setup_stb, .t_pio_direction, .t_d2h_data_stb, .t_if_activate,
    .send_sync_escape,
    .pio_data_ready, .pio_status_load, .pio_idle
  );

  dma_write_control u_dma_write_control (
    .clk, .command_layer_reset,
    .t_dma_activate_stb, .t_if_activate, .t_d2h_reg_stb, .send_sync_escape,
    .transport_layer_ready, .data_buffer_ready, .pio_idle,
    .command_layer_ready, .t_if_ready, .t_send_data_stb, .sync_escape
  );

  device_status_report u_device_status_report (
    .clk, .command_layer_reset,
    .t_d2h_reg_stb, .t_set_device_bits_stb, .pio_status_load, .pio_idle,
    .d2h_status, .d2h_error, .t_pio_e_status,
    .status, .error, .hard_drive_error
  );

  // Ready must drop while a PIO transfer is in flight
  a_busy_pio_blocks_ready : assert property (
    @(posedge clk) disable iff (command_layer_reset)
    (u_pio_control.state != PIO_IDLE) |-> !command_layer_ready
  );

endmodule
